// ==== build.f ====
verilog/cache_pkg.sv
verilog/line_mem_if.sv
verilog/l1_cache.sv
verilog/line_arbiter.sv
verilog/burst_adaptor.sv
verilog/cache_top.sv
sim/clock_gen.sv
sim/pmem_model.sv
sim/tb_cache_top.sv

// ==== Makefile ====
TOOL     = verilator
TOP      = tb_cache_top
FILELIST = build.f
FLAGS    = --binary --timing --assert --timescale 1ns/1ps --top-module $(TOP)
OBJDIR   = obj_dir
LOG      = sim.log

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --Mdir $(OBJDIR) -f $(FILELIST)
	./$(OBJDIR)/V$(TOP) | tee $(LOG)
	@if grep -q "Simulation failed" $(LOG); then exit 1; fi
	@grep -q "Simulation passed" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)

// ==== sim/tb_cache_top.sv ====
`default_nettype none

module tb_cache_top;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int S_INDEX     = 3;
    localparam int SETS        = 1 << S_INDEX;
    localparam int MIX_OPS     = 300;
    // directed plus random accesses, with margin
    localparam int ACCESSES    = 400;
    localparam int CYCLE_LIMIT = 200 * ACCESSES;
    // sampled one edge after driving, resp registered on the next
    localparam int HIT_CYCLES  = 2;

    localparam cache_pkg::addr_t IC_BASE    = 32'h0000_0000;
    localparam cache_pkg::addr_t DC_BASE    = 32'h0001_0000;
    localparam cache_pkg::addr_t FLUSH_BASE = 32'h0002_0000;

    logic              clk;
    logic              por_reset;
    logic              mid_reset;
    logic              reset;
    logic              icache_read_i;
    cache_pkg::addr_t  icache_address_i;
    cache_pkg::word_t  icache_rdata_o;
    logic              icache_resp_o;
    logic              dcache_read_i;
    logic              dcache_write_i;
    logic [3:0]        dcache_mbe_i;
    cache_pkg::addr_t  dcache_address_i;
    cache_pkg::word_t  dcache_wdata_i;
    cache_pkg::word_t  dcache_rdata_o;
    logic              dcache_resp_o;
    logic              pmem_read_o;
    logic              pmem_write_o;
    cache_pkg::addr_t  pmem_address_o;
    cache_pkg::beat_t  pmem_wdata_o;
    cache_pkg::beat_t  pmem_rdata_i;
    logic              pmem_resp_i;

    logic [7:0]        shadow [cache_pkg::addr_t];
    logic [31:0]       lfsr_q = 32'h418a;
    cache_pkg::word_t  ic_expect;
    cache_pkg::word_t  dc_expect;
    int ic_issued = 0;
    int dc_issued = 0;
    int ic_resp_count = 0;
    int dc_resp_count = 0;
    int data_errors = 0;
    int handshake_errors = 0;
    int timing_errors = 0;
    int cycle_count = 0;

    assign reset = por_reset || mid_reset;

    clock_gen #(.period_ns(8), .reset_cycles(5)) clock0 (.clk(clk), .reset_o(por_reset));

    cache_top #(.s_index(S_INDEX)) dut0 (
        .clk              (clk),
        .reset_i          (reset),
        .icache_read_i    (icache_read_i),
        .icache_address_i (icache_address_i),
        .icache_rdata_o   (icache_rdata_o),
        .icache_resp_o    (icache_resp_o),
        .dcache_read_i    (dcache_read_i),
        .dcache_write_i   (dcache_write_i),
        .dcache_mbe_i     (dcache_mbe_i),
        .dcache_address_i (dcache_address_i),
        .dcache_wdata_i   (dcache_wdata_i),
        .dcache_rdata_o   (dcache_rdata_o),
        .dcache_resp_o    (dcache_resp_o),
        .pmem_read_o      (pmem_read_o),
        .pmem_write_o     (pmem_write_o),
        .pmem_address_o   (pmem_address_o),
        .pmem_wdata_o     (pmem_wdata_o),
        .pmem_rdata_i     (pmem_rdata_i),
        .pmem_resp_i      (pmem_resp_i)
    );

    pmem_model #(.delay(3)) pmem0 (
        .clk            (clk),
        .reset_i        (reset),
        .pmem_read_i    (pmem_read_o),
        .pmem_write_i   (pmem_write_o),
        .pmem_address_i (pmem_address_o),
        .pmem_wdata_i   (pmem_wdata_o),
        .pmem_rdata_o   (pmem_rdata_i),
        .pmem_resp_o    (pmem_resp_i)
    );

    function automatic cache_pkg::word_t init_word(input cache_pkg::addr_t addr);
        return {addr[31:2], 2'b00} ^ 32'h5a3c_c3a5;
    endfunction

    // shadow bytes where written, initial memory contents elsewhere
    function automatic cache_pkg::word_t expected_word(input cache_pkg::addr_t addr);
        cache_pkg::word_t w;
        cache_pkg::addr_t a;
        w = init_word(addr);
        for (int b = 0; b < 4; b++) begin
            a = addr + cache_pkg::addr_t'(b);
            if (shadow.exists(a)) begin
                w[b * 8 +: 8] = shadow[a];
            end
        end
        return w;
    endfunction

    function automatic void shadow_write(input cache_pkg::addr_t addr, input logic [3:0] mbe,
                                         input cache_pkg::word_t wdata);
        for (int b = 0; b < 4; b++) begin
            if (mbe[b]) begin
                shadow[addr + cache_pkg::addr_t'(b)] = wdata[b * 8 +: 8];
            end
        end
    endfunction

    // taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] random_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = lfsr_step(lfsr_q);
            v = {v[30:0], lfsr_q[0]};
        end
        return v;
    endfunction

    task automatic fetch(input cache_pkg::addr_t addr, output int cycles);
        ic_expect = expected_word(addr);
        ic_issued++;
        @(posedge clk);
        icache_read_i    <= 1'b1;
        icache_address_i <= addr;
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
        end while (icache_resp_o !== 1'b1);
        @(posedge clk);
        icache_read_i <= 1'b0;
    endtask

    task automatic data_access(input logic write, input cache_pkg::addr_t addr,
                               input logic [3:0] mbe, input cache_pkg::word_t wdata);
        if (write) begin
            shadow_write(addr, mbe, wdata);
        end
        dc_expect = expected_word(addr);
        dc_issued++;
        @(posedge clk);
        dcache_read_i    <= !write;
        dcache_write_i   <= write;
        dcache_mbe_i     <= mbe;
        dcache_address_i <= addr;
        dcache_wdata_i   <= wdata;
        do begin
            @(negedge clk);
        end while (dcache_resp_o !== 1'b1);
        @(posedge clk);
        dcache_read_i  <= 1'b0;
        dcache_write_i <= 1'b0;
    endtask

    // clean lines into every set push dirty data out, then reset
    task automatic flush_and_reset();
        int ic_before;
        int dc_before;
        for (int s = 0; s < SETS; s++) begin
            data_access(1'b0, FLUSH_BASE + cache_pkg::addr_t'(s * 32), 4'b0000, '0);
        end
        @(posedge clk);
        mid_reset <= 1'b1;
        repeat (5) @(posedge clk);
        mid_reset <= 1'b0;
        ic_before = ic_resp_count;
        dc_before = dc_resp_count;
        repeat (10) @(negedge clk);
        assert (ic_resp_count == ic_before && dc_resp_count == dc_before) else begin
            timing_errors++;
            $display("%0t: a resp output rose after reset with no request", $time);
        end
        assert (pmem_read_o === 1'b0 && pmem_write_o === 1'b0) else begin
            handshake_errors++;
            $display("%0t: a pmem request is raised after reset with no miss", $time);
        end
    endtask

    always @(negedge clk) begin
        if (icache_resp_o === 1'b1) begin
            assert (ic_issued > ic_resp_count) else begin
                handshake_errors++;
                $display("%0t: icache_resp_o pulsed with no request pending", $time);
            end
            if (ic_issued > ic_resp_count) begin
                assert (icache_rdata_o === ic_expect) else begin
                    data_errors++;
                    $display("FAILED at %0t: icache_rdata_o expected %h, got %h",
                             $time, ic_expect, icache_rdata_o);
                end
            end
            ic_resp_count++;
        end
        if (dcache_resp_o === 1'b1) begin
            assert (dc_issued > dc_resp_count) else begin
                handshake_errors++;
                $display("%0t: dcache_resp_o pulsed with no request pending", $time);
            end
            if (dc_issued > dc_resp_count) begin
                assert (dcache_rdata_o === dc_expect) else begin
                    data_errors++;
                    $display("FAILED at %0t: dcache_rdata_o expected %h, got %h",
                             $time, dc_expect, dcache_rdata_o);
                end
            end
            dc_resp_count++;
        end
        // memory side requests are line aligned and one direction at a time
        if (pmem_read_o === 1'b1 || pmem_write_o === 1'b1) begin
            assert (!(pmem_read_o === 1'b1 && pmem_write_o === 1'b1)) else begin
                handshake_errors++;
                $display("%0t: pmem_read_o and pmem_write_o raised together", $time);
            end
            assert (pmem_address_o[4:0] === 5'd0) else begin
                handshake_errors++;
                $display("%0t: pmem_address_o %h is not line aligned",
                         $time, pmem_address_o);
            end
        end
    end

    // watchdog
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Simulation failed");
            $finish;
        end
    end

    initial begin
        int               cycles;
        int               ic_before;
        int               dc_before;
        cache_pkg::addr_t a;
        logic [2:0]       w3;
        logic [1:0]       op;
        icache_read_i    = 1'b0;
        icache_address_i = '0;
        dcache_read_i    = 1'b0;
        dcache_write_i   = 1'b0;
        dcache_mbe_i     = 4'b0000;
        dcache_address_i = '0;
        dcache_wdata_i   = '0;
        mid_reset        = 1'b0;
        wait (por_reset == 1'b0);
        @(posedge clk);

        // fetch fill, then a hit elsewhere in the same line
        for (int i = 0; i < 8; i++) begin
            a = IC_BASE + (random_bits(9) << 2);
            fetch(a, cycles);
            w3 = 3'(random_bits(3));
            fetch({a[31:5], w3, 2'b00}, cycles);
            assert (cycles == HIT_CYCLES) else begin
                timing_errors++;
                $display("FAILED at %0t: icache_resp_o latency expected %0d, got %0d",
                         $time, HIT_CYCLES, cycles);
            end
        end

        // byte enable writes, read back
        for (int i = 0; i < 6; i++) begin
            a = DC_BASE + (random_bits(8) << 2);
            data_access(1'b1, a, 4'(random_bits(4)), random_bits(32));
            data_access(1'b0, a, 4'b0000, '0);
        end

        // dirty victim evicted by two lines of the same index
        a = DC_BASE + 32'h0000_0804;
        data_access(1'b1, a, 4'b1111, random_bits(32));
        data_access(1'b0, a + 32'h100, 4'b0000, '0);
        data_access(1'b0, a + 32'h200, 4'b0000, '0);
        data_access(1'b0, a, 4'b0000, '0);

        // both caches miss in the same cycle
        ic_before = ic_resp_count;
        dc_before = dc_resp_count;
        fork
            fetch(IC_BASE + 32'h0000_4010, cycles);
            data_access(1'b0, DC_BASE + 32'h0000_6018, 4'b0000, '0);
        join
        repeat (4) @(negedge clk);
        assert (ic_resp_count == ic_before + 1 && dc_resp_count == dc_before + 1) else begin
            timing_errors++;
            $display("%0t: concurrent misses did not give one resp per cache", $time);
        end

        // random mix with a reset half way
        for (int i = 0; i < MIX_OPS; i++) begin
            if (i == MIX_OPS / 2) begin
                flush_and_reset();
            end
            op = 2'(random_bits(2));
            if (op == 2'd0) begin
                fetch(IC_BASE + (random_bits(9) << 2), cycles);
            end else if (op == 2'd1) begin
                data_access(1'b0, DC_BASE + (random_bits(8) << 2), 4'b0000, '0);
            end else begin
                a = DC_BASE + (random_bits(8) << 2);
                data_access(1'b1, a, 4'(random_bits(4)), random_bits(32));
            end
        end

        repeat (4) @(negedge clk);
        $display("errors: data %0d, handshake %0d, timing %0d",
                 data_errors, handshake_errors, timing_errors);
        if (data_errors + handshake_errors + timing_errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== sim/pmem_model.sv ====
`default_nettype none

module pmem_model #(
    parameter int delay = 3
) (
    input  logic              clk,
    input  logic              reset_i,
    input  logic              pmem_read_i,
    input  logic              pmem_write_i,
    input  cache_pkg::addr_t  pmem_address_i,
    input  cache_pkg::beat_t  pmem_wdata_i,
    output cache_pkg::beat_t  pmem_rdata_o = '0,
    output logic              pmem_resp_o = 1'b0
);
    timeunit 1ns;
    timeprecision 100ps;

    localparam int BEATS = 4;

    // sparse storage, keyed by beat-aligned byte address
    cache_pkg::beat_t mem [cache_pkg::addr_t];

    logic       busy_q = 1'b0;
    int         step_q = 0;
    logic [1:0] beat_q = 2'd0;

    // every word starts as its own address mixed with a pattern
    function automatic cache_pkg::word_t init_word(input cache_pkg::addr_t addr);
        return {addr[31:2], 2'b00} ^ 32'h5a3c_c3a5;
    endfunction

    function automatic cache_pkg::addr_t beat_addr(input logic [1:0] k);
        return {pmem_address_i[31:5], k, 3'b000};
    endfunction

    function automatic cache_pkg::beat_t read_beat(input cache_pkg::addr_t addr);
        if (mem.exists(addr)) begin
            return mem[addr];
        end
        // lower word sits at the lower address
        return {init_word(addr + 32'd4), init_word(addr)};
    endfunction

    always @(posedge clk) begin
        if (reset_i) begin
            busy_q       <= 1'b0;
            step_q       <= 0;
            beat_q       <= 2'd0;
            pmem_resp_o  <= 1'b0;
            pmem_rdata_o <= '0;
        end else begin
            // write beat taken in the cycle it was acknowledged
            if (pmem_resp_o && pmem_write_i) begin
                mem[beat_addr(beat_q)] = pmem_wdata_i;
            end
            if (!busy_q) begin
                pmem_resp_o <= 1'b0;
                if (pmem_read_i || pmem_write_i) begin
                    busy_q <= 1'b1;
                    step_q <= 1;
                end
            end else if (step_q == delay - 1 + BEATS) begin
                busy_q      <= 1'b0;
                pmem_resp_o <= 1'b0;
            end else begin
                step_q <= step_q + 1;
                if (step_q >= delay - 1) begin
                    pmem_resp_o  <= 1'b1;
                    beat_q       <= 2'(step_q - (delay - 1));
                    pmem_rdata_o <= read_beat(beat_addr(2'(step_q - (delay - 1))));
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== sim/clock_gen.sv ====
`default_nettype none

module clock_gen #(
    parameter int period_ns    = 8,
    parameter int reset_cycles = 5
) (
    output logic clk,
    output logic reset_o
);
    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        clk = 1'b0;
        forever #(period_ns / 2) clk = ~clk;
    end

    // power-on reset, released on a rising edge
    initial begin
        reset_o = 1'b1;
        repeat (reset_cycles) @(posedge clk);
        reset_o <= 1'b0;
    end

endmodule

`default_nettype wire

// ==== verilog/cache_top.sv ====
`default_nettype none

module cache_top #(
    parameter int s_index = 3
) (
    input  logic              clk,
    input  logic              reset_i,

    // instruction side
    input  logic              icache_read_i,
    input  cache_pkg::addr_t  icache_address_i,
    output cache_pkg::word_t  icache_rdata_o,
    output logic              icache_resp_o,

    // data side
    input  logic              dcache_read_i,
    input  logic              dcache_write_i,
    input  logic [3:0]        dcache_mbe_i,
    input  cache_pkg::addr_t  dcache_address_i,
    input  cache_pkg::word_t  dcache_wdata_i,
    output cache_pkg::word_t  dcache_rdata_o,
    output logic              dcache_resp_o,

    // physical memory
    output logic              pmem_read_o,
    output logic              pmem_write_o,
    output cache_pkg::addr_t  pmem_address_o,
    output cache_pkg::beat_t  pmem_wdata_o,
    input  cache_pkg::beat_t  pmem_rdata_i,
    input  logic              pmem_resp_i
);

    line_mem_if ic_line ();
    line_mem_if dc_line ();
    line_mem_if mem_line ();

    // read-only, write inputs tied off
    l1_cache #(
        .s_index     (s_index),
        .allow_write (1'b0)
    ) icache (
        .clk           (clk),
        .reset_i       (reset_i),
        .mem_read_i    (icache_read_i),
        .mem_write_i   (1'b0),
        .mem_mbe_i     (4'b1111),
        .mem_address_i (icache_address_i),
        .mem_wdata_i   ('0),
        .mem_rdata_o   (icache_rdata_o),
        .mem_resp_o    (icache_resp_o),
        .line          (ic_line.requester)
    );

    l1_cache #(
        .s_index     (s_index),
        .allow_write (1'b1)
    ) dcache (
        .clk           (clk),
        .reset_i       (reset_i),
        .mem_read_i    (dcache_read_i),
        .mem_write_i   (dcache_write_i),
        .mem_mbe_i     (dcache_mbe_i),
        .mem_address_i (dcache_address_i),
        .mem_wdata_i   (dcache_wdata_i),
        .mem_rdata_o   (dcache_rdata_o),
        .mem_resp_o    (dcache_resp_o),
        .line          (dc_line.requester)
    );

    line_arbiter arbiter (
        .clk     (clk),
        .reset_i (reset_i),
        .dc      (dc_line.responder),
        .ic      (ic_line.responder),
        .mem     (mem_line.requester)
    );

    burst_adaptor adaptor (
        .clk            (clk),
        .reset_i        (reset_i),
        .line           (mem_line.responder),
        .pmem_read_o    (pmem_read_o),
        .pmem_write_o   (pmem_write_o),
        .pmem_address_o (pmem_address_o),
        .pmem_wdata_o   (pmem_wdata_o),
        .pmem_rdata_i   (pmem_rdata_i),
        .pmem_resp_i    (pmem_resp_i)
    );

endmodule

`default_nettype wire

// ==== verilog/burst_adaptor.sv ====
`default_nettype none

module burst_adaptor (
    input  logic              clk,
    input  logic              reset_i,

    line_mem_if.responder     line,

    output logic              pmem_read_o,
    output logic              pmem_write_o,
    output cache_pkg::addr_t  pmem_address_o,
    output cache_pkg::beat_t  pmem_wdata_o,
    input  cache_pkg::beat_t  pmem_rdata_i,
    input  logic              pmem_resp_i
);

    localparam int BEAT_BITS = $bits(cache_pkg::beat_t);
    localparam int LINE_BITS = $bits(cache_pkg::line_t);
    localparam logic [1:0] LAST_BEAT = 2'(cache_pkg::BEATS_PER_LINE - 1);

    cache_pkg::adaptor_state_e state_q;
    logic [1:0]                beat_cnt_q;
    cache_pkg::line_t          shift_q;
    cache_pkg::addr_t          addr_q;
    logic                      in_burst;
    logic                      last_beat;

    assign in_burst  = (state_q == cache_pkg::AD_READ_BURST)
                       || (state_q == cache_pkg::AD_WRITE_BURST);
    assign last_beat = in_burst && pmem_resp_i && (beat_cnt_q == LAST_BEAT);

    always_ff @(posedge clk) begin
        if (reset_i) begin
            state_q    <= cache_pkg::AD_IDLE;
            beat_cnt_q <= 2'd0;
        end else begin
            case (state_q)
                cache_pkg::AD_IDLE: begin
                    beat_cnt_q <= 2'd0;
                    if (line.write) begin
                        state_q <= cache_pkg::AD_WRITE_BURST;
                    end else if (line.read) begin
                        state_q <= cache_pkg::AD_READ_BURST;
                    end
                end
                cache_pkg::AD_READ_BURST, cache_pkg::AD_WRITE_BURST: begin
                    if (pmem_resp_i) begin
                        beat_cnt_q <= beat_cnt_q + 2'd1;
                    end
                    if (last_beat) begin
                        state_q <= cache_pkg::AD_DONE;
                    end
                end
                // resp cycle, request is dropped after it
                default: begin
                    state_q <= cache_pkg::AD_IDLE;
                end
            endcase
        end
    end

    // one register serves both directions:
    // write beats leave from the bottom, read beats enter at the top
    always_ff @(posedge clk) begin
        if (state_q == cache_pkg::AD_IDLE) begin
            shift_q <= line.wdata;
            addr_q  <= line.address;
        end else if (in_burst && pmem_resp_i) begin
            shift_q <= {pmem_rdata_i, shift_q[LINE_BITS-1:BEAT_BITS]};
        end
    end

    assign pmem_read_o    = (state_q == cache_pkg::AD_READ_BURST);
    assign pmem_write_o   = (state_q == cache_pkg::AD_WRITE_BURST);
    assign pmem_address_o = addr_q;
    assign pmem_wdata_o   = shift_q[BEAT_BITS-1:0];

    assign line.rdata = shift_q;
    assign line.resp  = (state_q == cache_pkg::AD_DONE);

endmodule

`default_nettype wire

// ==== verilog/line_arbiter.sv ====
`default_nettype none

module line_arbiter (
    input  logic          clk,
    input  logic          reset_i,

    line_mem_if.responder dc,
    line_mem_if.responder ic,
    line_mem_if.requester mem
);

    cache_pkg::grant_e grant_q;
    logic              issued_q;
    logic              mem_read_q;
    logic              mem_write_q;
    logic              dc_resp_q;
    logic              ic_resp_q;
    cache_pkg::addr_t  addr_q;
    cache_pkg::line_t  wdata_q;
    cache_pkg::line_t  rdata_q;

    logic              sel_read;
    logic              sel_write;
    cache_pkg::addr_t  sel_address;
    cache_pkg::line_t  sel_wdata;
    logic              owner_resp;

    // request of the current owner
    always_comb begin
        if (grant_q == cache_pkg::GNT_ICACHE) begin
            sel_read    = ic.read;
            sel_write   = ic.write;
            sel_address = ic.address;
            sel_wdata   = ic.wdata;
        end else begin
            sel_read    = dc.read;
            sel_write   = dc.write;
            sel_address = dc.address;
            sel_wdata   = dc.wdata;
        end
    end

    assign owner_resp = dc_resp_q || ic_resp_q;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            grant_q     <= cache_pkg::GNT_NONE;
            issued_q    <= 1'b0;
            mem_read_q  <= 1'b0;
            mem_write_q <= 1'b0;
            dc_resp_q   <= 1'b0;
            ic_resp_q   <= 1'b0;
        end else begin
            dc_resp_q <= 1'b0;
            ic_resp_q <= 1'b0;
            if (grant_q == cache_pkg::GNT_NONE) begin
                // data side first on a tie
                if (dc.read || dc.write) begin
                    grant_q <= cache_pkg::GNT_DCACHE;
                end else if (ic.read || ic.write) begin
                    grant_q <= cache_pkg::GNT_ICACHE;
                end
            end else if (owner_resp) begin
                grant_q  <= cache_pkg::GNT_NONE;
                issued_q <= 1'b0;
            end else if (mem.resp) begin
                // drop toward memory, answer the owner next cycle
                mem_read_q  <= 1'b0;
                mem_write_q <= 1'b0;
                dc_resp_q   <= (grant_q == cache_pkg::GNT_DCACHE);
                ic_resp_q   <= (grant_q == cache_pkg::GNT_ICACHE);
            end else if (!issued_q) begin
                mem_read_q  <= sel_read;
                mem_write_q <= sel_write;
                issued_q    <= 1'b1;
            end
        end
    end

    // registered payload in both directions
    always_ff @(posedge clk) begin
        if ((grant_q != cache_pkg::GNT_NONE) && !issued_q) begin
            addr_q  <= sel_address;
            wdata_q <= sel_wdata;
        end
        if (mem.resp) begin
            rdata_q <= mem.rdata;
        end
    end

    assign mem.read    = mem_read_q;
    assign mem.write   = mem_write_q;
    assign mem.address = addr_q;
    assign mem.wdata   = wdata_q;

    assign dc.rdata = rdata_q;
    assign dc.resp  = dc_resp_q;
    assign ic.rdata = rdata_q;
    assign ic.resp  = ic_resp_q;

endmodule

`default_nettype wire

// ==== verilog/l1_cache.sv ====
`default_nettype none

module l1_cache #(
    parameter int s_index     = 3,
    parameter bit allow_write = 1'b1
) (
    input  logic              clk,
    input  logic              reset_i,

    input  logic              mem_read_i,
    input  logic              mem_write_i,
    input  logic [3:0]        mem_mbe_i,
    input  cache_pkg::addr_t  mem_address_i,
    input  cache_pkg::word_t  mem_wdata_i,
    output cache_pkg::word_t  mem_rdata_o,
    output logic              mem_resp_o,

    line_mem_if.requester     line
);

    localparam int SETS      = 1 << s_index;
    localparam int ADDR_BITS = $bits(cache_pkg::addr_t);
    localparam int TAG_BITS  = ADDR_BITS - cache_pkg::OFFSET_BITS - s_index;
    localparam int WORD_BITS = $bits(cache_pkg::word_t);

    // storage arrays
    cache_pkg::line_t     data_q [SETS];
    logic [TAG_BITS-1:0]  tag_q  [SETS];
    logic [SETS-1:0]      valid_q;
    logic [SETS-1:0]      dirty_q;

    cache_pkg::l1_state_e state_q;

    logic [s_index-1:0]   idx;
    logic [TAG_BITS-1:0]  req_tag;
    logic [2:0]           word_sel;
    logic                 wr_req;
    logic                 req;
    logic                 hit;
    logic                 victim_dirty;
    logic                 access;
    cache_pkg::line_t     merged_line;

    // address split
    assign idx      = mem_address_i[cache_pkg::OFFSET_BITS +: s_index];
    assign req_tag  = mem_address_i[ADDR_BITS-1 -: TAG_BITS];
    assign word_sel = mem_address_i[cache_pkg::OFFSET_BITS-1:2];

    // write path folds away in the instruction cache
    assign wr_req = allow_write && mem_write_i;

    // request is still held during the resp cycle, so skip it there
    assign req          = (mem_read_i || wr_req) && !mem_resp_o;
    assign hit          = valid_q[idx] && (tag_q[idx] == req_tag);
    assign victim_dirty = allow_write && valid_q[idx] && dirty_q[idx];

    // hit from idle, or replay once the line is filled
    assign access = ((state_q == cache_pkg::L1_IDLE) && req && hit)
                    || (state_q == cache_pkg::L1_RESPOND);

    // byte merge into the selected word
    always_comb begin
        merged_line = data_q[idx];
        if (wr_req) begin
            for (int b = 0; b < 4; b++) begin
                if (mem_mbe_i[b]) begin
                    merged_line[int'(word_sel) * WORD_BITS + b * 8 +: 8] =
                        mem_wdata_i[b * 8 +: 8];
                end
            end
        end
    end

    // line side requests come straight from the state
    assign line.read  = (state_q == cache_pkg::L1_FILL);
    assign line.write = (state_q == cache_pkg::L1_WRITEBACK);
    assign line.wdata = data_q[idx];

    always_comb begin
        if (state_q == cache_pkg::L1_WRITEBACK) begin
            // victim goes back to its own address
            line.address = {tag_q[idx], idx, {cache_pkg::OFFSET_BITS{1'b0}}};
        end else begin
            line.address = {req_tag, idx, {cache_pkg::OFFSET_BITS{1'b0}}};
        end
    end

    // control and status bits
    always_ff @(posedge clk) begin
        if (reset_i) begin
            state_q    <= cache_pkg::L1_IDLE;
            mem_resp_o <= 1'b0;
            valid_q    <= '0;
            dirty_q    <= '0;
        end else begin
            mem_resp_o <= access;
            if (access && wr_req) begin
                dirty_q[idx] <= 1'b1;
            end
            case (state_q)
                cache_pkg::L1_IDLE: begin
                    if (req && !hit) begin
                        state_q <= victim_dirty ? cache_pkg::L1_WRITEBACK
                                                : cache_pkg::L1_FILL;
                    end
                end
                cache_pkg::L1_WRITEBACK: begin
                    if (line.resp) begin
                        state_q <= cache_pkg::L1_FILL;
                    end
                end
                cache_pkg::L1_FILL: begin
                    if (line.resp) begin
                        state_q      <= cache_pkg::L1_RESPOND;
                        valid_q[idx] <= 1'b1;
                        dirty_q[idx] <= 1'b0;
                    end
                end
                cache_pkg::L1_RESPOND: begin
                    state_q <= cache_pkg::L1_IDLE;
                end
                default: begin
                    state_q <= cache_pkg::L1_IDLE;
                end
            endcase
        end
    end

    // data, tags and read word
    always_ff @(posedge clk) begin
        if ((state_q == cache_pkg::L1_FILL) && line.resp) begin
            data_q[idx] <= line.rdata;
            tag_q[idx]  <= req_tag;
        end else if (access && wr_req) begin
            data_q[idx] <= merged_line;
        end
        // a write returns the updated word
        if (access) begin
            mem_rdata_o <= merged_line[int'(word_sel) * WORD_BITS +: WORD_BITS];
        end
    end

endmodule

`default_nettype wire

// ==== verilog/line_mem_if.sv ====
`default_nettype none

interface line_mem_if;

    // request levels, held until resp
    logic              read;
    logic              write;
    // line aligned
    cache_pkg::addr_t  address;
    cache_pkg::line_t  wdata;

    // valid in the resp cycle
    cache_pkg::line_t  rdata;
    logic              resp;

    modport requester (
        output read,
        output write,
        output address,
        output wdata,
        input  rdata,
        input  resp
    );

    modport responder (
        input  read,
        input  write,
        input  address,
        input  wdata,
        output rdata,
        output resp
    );

endinterface

`default_nettype wire

// ==== verilog/cache_pkg.sv ====
`default_nettype none

package cache_pkg;

    // core and memory widths
    typedef logic [31:0]  addr_t;
    typedef logic [31:0]  word_t;
    typedef logic [255:0] line_t;
    typedef logic [63:0]  beat_t;

    // 32-byte lines moved as four 64-bit beats
    localparam int BEATS_PER_LINE = 4;
    localparam int OFFSET_BITS    = 5;

    // l1 miss handling
    typedef enum logic [1:0] {
        L1_IDLE,
        L1_WRITEBACK,
        L1_FILL,
        L1_RESPOND
    } l1_state_e;

    // burst adaptor sequencing
    typedef enum logic [1:0] {
        AD_IDLE,
        AD_READ_BURST,
        AD_WRITE_BURST,
        AD_DONE
    } adaptor_state_e;

    // owner of the shared line path
    typedef enum logic [1:0] {
        GNT_NONE,
        GNT_DCACHE,
        GNT_ICACHE
    } grant_e;

endpackage

`default_nettype wire
